/* common/led_core_pkg.sv */
/*
 * Shared widths, register map and scan states of the LED matrix core.
 * Modules pull these in with a wildcard import in their headers.
 */
`default_nettype none

package led_core_pkg;

    // ------------------------------------------------------------
    // pixel and image geometry
    localparam int PIXEL_DEPTH      = 6;   // bits kept per colour
    localparam int IMG_WIDTH_LOG2   = 7;   // horizontal address, image width reg
    localparam int IMG_V_LOG2       = 7;   // vertical address
    localparam int LANE_HEIGHT_LOG2 = 5;   // lane height reg, hub row address
    localparam int BUF_ADDR_WIDTH   = IMG_WIDTH_LOG2 + LANE_HEIGHT_LOG2;
    localparam int PIX_WIDTH        = 3 * PIXEL_DEPTH;   // packed rgb word
    localparam int BRIGHTNESS_DEPTH = 5;   // pwm counter

    // ------------------------------------------------------------
    // apb register file
    localparam int APB_ADDR_WIDTH = 4;
    localparam int APB_DATA_WIDTH = 16;

    localparam logic [APB_DATA_WIDTH-1:0] VERSION_VALUE = 16'h0201;

    // word addresses
    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        GCTRL       = 4'd0,   // bit 0 scan enable, bit 1 hpd trigger function
        BRIGHTNESS  = 4'd1,
        IMAGE_WIDTH = 4'd2,
        LANE_HEIGHT = 4'd3,
        ROI_X0      = 4'd4,
        ROI_Y0      = 4'd5,
        VERSION     = 4'd6    // read only
    } reg_addr_e;

    // hub scan sequencer
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_SHIFT,
        SCAN_LATCH
    } scan_state_e;

endpackage

`default_nettype wire

/* frame_buffer/image_clipper.sv */
/*
 * Cuts one lane's window out of the pixel stream and turns the pixel
 * into a registered write to that lane's buffer.
 */
`default_nettype none

module image_clipper import led_core_pkg::*;
#(
    parameter int LANE_INDEX = 0
)
(
    input  logic                          clk_pll_dclk,
    input  logic                          dly_rst,
    input  logic                          pix_valid,
    input  logic [IMG_WIDTH_LOG2-1:0]     pix_h,
    input  logic [IMG_V_LOG2-1:0]         pix_v,
    input  logic [7:0]                    pix_r,
    input  logic [7:0]                    pix_g,
    input  logic [7:0]                    pix_b,
    input  logic [IMG_WIDTH_LOG2-1:0]     image_width,
    input  logic [LANE_HEIGHT_LOG2-1:0]   lane_height,
    input  logic [IMG_WIDTH_LOG2-1:0]     roi_x0,
    input  logic [IMG_V_LOG2-1:0]         roi_y0,
    output logic                          wr_en,
    output logic [BUF_ADDR_WIDTH-1:0]     wr_addr,
    output logic [PIX_WIDTH-1:0]          wr_data
);

    localparam int VW = IMG_V_LOG2 + LANE_HEIGHT_LOG2 + 4;   // room for lane offset

    logic [VW-1:0]             lane_y0;   // first image row of this lane
    logic [VW-1:0]             dy;        // wraps high when above the lane
    logic [IMG_WIDTH_LOG2:0]   dx;        // extra bit catches left of roi
    logic                      in_win;

    assign lane_y0 = VW'(roi_y0) + VW'(LANE_INDEX) * VW'(lane_height);
    assign dy      = VW'(pix_v) - lane_y0;
    assign dx      = {1'b0, pix_h} - {1'b0, roi_x0};
    assign in_win  = dx < {1'b0, image_width} && dy < VW'(lane_height);

    always_ff @(posedge clk_pll_dclk or posedge dly_rst)
    begin
        if (dly_rst)
            wr_en <= 1'b0;
        else
            wr_en <= pix_valid && in_win;
    end

    // payload, row major inside the lane
    always_ff @(posedge clk_pll_dclk)
    begin
        wr_addr <= BUF_ADDR_WIDTH'(dy[LANE_HEIGHT_LOG2-1:0]) * BUF_ADDR_WIDTH'(image_width)
                 + BUF_ADDR_WIDTH'(dx[IMG_WIDTH_LOG2-1:0]);
        wr_data <= {pix_r[7 -: PIXEL_DEPTH], pix_g[7 -: PIXEL_DEPTH], pix_b[7 -: PIXEL_DEPTH]};
    end

    // write stays inside the lane area set up one cycle earlier
    a_wr_in_lane: assert property (
        @(posedge clk_pll_dclk) disable iff (dly_rst)
        wr_en |-> int'(wr_addr) < int'($past(image_width)) * int'($past(lane_height))
    ) else $error("lane %0d write outside buffer area", LANE_INDEX);

endmodule

`default_nettype wire

/* frame_buffer/lane_buffer.sv */
/*
 * Pixel store for one panel lane. Written by the clipper, read by the
 * scan driver with one cycle of read latency.
 */
`default_nettype none

module lane_buffer import led_core_pkg::*;
(
    input  logic                        clk_pll_dclk,
    input  logic                        wr_en,
    input  logic [BUF_ADDR_WIDTH-1:0]   wr_addr,
    input  logic [PIX_WIDTH-1:0]        wr_data,
    input  logic [BUF_ADDR_WIDTH-1:0]   rd_addr,
    output logic [PIX_WIDTH-1:0]        rd_data
);

    // simple dual port, maps to block ram
    logic [PIX_WIDTH-1:0] mem [2**BUF_ADDR_WIDTH];

    always_ff @(posedge clk_pll_dclk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];   // registered read
    end

endmodule

`default_nettype wire

/* src/apb_regfile.sv */
/*
 * APB slave with the core control registers and a read-only version word.
 * Zero wait states. Bad addresses and version writes answer with pslverr.
 */
`default_nettype none

module apb_regfile import led_core_pkg::*;
(
    input  logic                          clk_pll_dclk,
    input  logic                          dly_rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [APB_ADDR_WIDTH-1:0]     paddr,
    input  logic [APB_DATA_WIDTH-1:0]     pwdata,
    output logic [APB_DATA_WIDTH-1:0]     prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic [1:0]                    gctrl,
    output logic [BRIGHTNESS_DEPTH-1:0]   brightness,
    output logic [IMG_WIDTH_LOG2-1:0]     image_width,
    output logic [LANE_HEIGHT_LOG2-1:0]   lane_height,
    output logic [IMG_WIDTH_LOG2-1:0]     roi_x0,
    output logic [IMG_V_LOG2-1:0]         roi_y0
);

    reg_addr_e addr;
    logic      access;     // apb access phase
    logic      wr_ok;

    assign addr    = reg_addr_e'(paddr);
    assign access  = psel && penable;
    assign pready  = 1'b1;               // never stalls
    assign pslverr = access && (paddr > VERSION || (pwrite && addr == VERSION));
    assign wr_ok   = access && pwrite && !pslverr;

    // ------------------------------------------------------------
    // writable registers
    always_ff @(posedge clk_pll_dclk or posedge dly_rst)
    begin
        if (dly_rst)
        begin
            gctrl       <= '0;                           // scan off
            brightness  <= BRIGHTNESS_DEPTH'(16);        // half duty
            image_width <= IMG_WIDTH_LOG2'(64);
            lane_height <= LANE_HEIGHT_LOG2'(16);
            roi_x0      <= '0;
            roi_y0      <= '0;
        end
        else if (wr_ok)
        begin
            case (addr)
                GCTRL:       gctrl       <= pwdata[1:0];
                BRIGHTNESS:  brightness  <= pwdata[BRIGHTNESS_DEPTH-1:0];
                IMAGE_WIDTH: image_width <= pwdata[IMG_WIDTH_LOG2-1:0];
                LANE_HEIGHT: lane_height <= pwdata[LANE_HEIGHT_LOG2-1:0];
                ROI_X0:      roi_x0      <= pwdata[IMG_WIDTH_LOG2-1:0];
                ROI_Y0:      roi_y0      <= pwdata[IMG_V_LOG2-1:0];
                default:     ;                           // version, unmapped
            endcase
        end
    end

    // read mux, zero extended
    always_comb
    begin
        case (addr)
            GCTRL:       prdata = APB_DATA_WIDTH'(gctrl);
            BRIGHTNESS:  prdata = APB_DATA_WIDTH'(brightness);
            IMAGE_WIDTH: prdata = APB_DATA_WIDTH'(image_width);
            LANE_HEIGHT: prdata = APB_DATA_WIDTH'(lane_height);
            ROI_X0:      prdata = APB_DATA_WIDTH'(roi_x0);
            ROI_Y0:      prdata = APB_DATA_WIDTH'(roi_y0);
            VERSION:     prdata = VERSION_VALUE;
            default:     prdata = '0;
        endcase
    end

    // master must open every transfer with a setup phase
    a_penable_needs_psel: assert property (
        @(posedge clk_pll_dclk) disable iff (dly_rst) penable |-> psel
    ) else $error("apb penable without psel");

endmodule

`default_nettype wire

/* src/scan_driver.sv */
/*
 * HUB scan sequencer. Walks the lane buffers row by row, shifts one pixel
 * per hub_clk strobe for all lanes at once and latches each finished row.
 */
`default_nettype none

module scan_driver import led_core_pkg::*;
#(
    parameter int NUM_LANES = 3
)
(
    input  logic                                clk_pll_dclk,
    input  logic                                dly_rst,
    input  logic                                scan_en,
    input  logic [IMG_WIDTH_LOG2-1:0]           image_width,
    input  logic [LANE_HEIGHT_LOG2-1:0]         lane_height,
    output logic [BUF_ADDR_WIDTH-1:0]           rd_addr,
    input  logic [NUM_LANES-1:0][PIX_WIDTH-1:0] rd_data,
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]    hub_r,
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]    hub_g,
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]    hub_b,
    output logic                                hub_clk,
    output logic                                hub_latch,
    output logic [LANE_HEIGHT_LOG2-1:0]         hub_addr
);

    scan_state_e                 state;
    logic [IMG_WIDTH_LOG2-1:0]   col;
    logic [LANE_HEIGHT_LOG2-1:0] row;
    logic                        last_col;
    logic                        last_row;

    assign last_col = col == image_width - 1'b1;
    assign last_row = row == lane_height - 1'b1;
    assign rd_addr  = BUF_ADDR_WIDTH'(row) * BUF_ADDR_WIDTH'(image_width)
                    + BUF_ADDR_WIDTH'(col);

    // ------------------------------------------------------------
    // row / column sequencer
    always_ff @(posedge clk_pll_dclk or posedge dly_rst)
    begin
        if (dly_rst)
        begin
            state <= SCAN_IDLE;
            col   <= '0;
            row   <= '0;
        end
        else
        begin
            case (state)
                SCAN_IDLE:
                begin
                    col <= '0;
                    row <= '0;
                    if (scan_en)
                        state <= SCAN_SHIFT;
                end
                SCAN_SHIFT:                          // one buffer read per cycle
                begin
                    if (last_col)
                    begin
                        col   <= '0;
                        state <= SCAN_LATCH;
                    end
                    else
                        col <= col + 1'b1;
                end
                SCAN_LATCH:
                begin
                    row   <= last_row ? '0 : row + 1'b1;    // wrap to top of lane
                    state <= scan_en ? SCAN_SHIFT : SCAN_IDLE;
                end
                default:
                    state <= SCAN_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // output stage, strobe follows the read by one cycle
    always_ff @(posedge clk_pll_dclk or posedge dly_rst)
    begin
        if (dly_rst)
        begin
            hub_clk   <= 1'b0;
            hub_latch <= 1'b0;
            hub_addr  <= '0;
        end
        else
        begin
            hub_clk   <= state == SCAN_SHIFT;    // read data lands with it
            hub_latch <= state == SCAN_LATCH;    // after last strobe of row
            if (state == SCAN_LATCH)
                hub_addr <= row;                 // row just shifted
        end
    end

    // split rgb words onto the lane data pins
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : g_hub
        assign hub_r[k*PIXEL_DEPTH +: PIXEL_DEPTH] = rd_data[k][PIX_WIDTH-1 -: PIXEL_DEPTH];
        assign hub_g[k*PIXEL_DEPTH +: PIXEL_DEPTH] = rd_data[k][2*PIXEL_DEPTH-1 -: PIXEL_DEPTH];
        assign hub_b[k*PIXEL_DEPTH +: PIXEL_DEPTH] = rd_data[k][PIXEL_DEPTH-1:0];
    end

    a_clk_latch_apart: assert property (
        @(posedge clk_pll_dclk) disable iff (dly_rst) !(hub_clk && hub_latch)
    ) else $error("hub_clk and hub_latch high together");

endmodule

`default_nettype wire

/* src/panel_enable_ctrl.sv */
/*
 * Brightness PWM on the panel output enable and the power-on hold-off
 * of the HPD trigger output.
 */
`default_nettype none

module panel_enable_ctrl import led_core_pkg::*;
#(
    parameter int PON_DELAY_CYCLES = 64
)
(
    input  logic                          clk_pll_dclk,
    input  logic                          dly_rst,
    input  logic                          scan_en,
    input  logic                          hpd_func,
    input  logic [BRIGHTNESS_DEPTH-1:0]   brightness,
    output logic                          hub_oe_n,
    output logic                          hpd_trig
);

    localparam int PON_W = $clog2(PON_DELAY_CYCLES + 1);

    logic [BRIGHTNESS_DEPTH-1:0] pwm_cnt;   // free running
    logic [PON_W-1:0]            pon_cnt;   // saturates at the delay
    logic                        pon_done;

    assign pon_done = pon_cnt == PON_W'(PON_DELAY_CYCLES);

    always_ff @(posedge clk_pll_dclk or posedge dly_rst)
    begin
        if (dly_rst)
        begin
            pwm_cnt  <= '0;
            pon_cnt  <= '0;
            hub_oe_n <= 1'b1;                 // dark
        end
        else
        begin
            pwm_cnt  <= pwm_cnt + 1'b1;
            if (!pon_done)
                pon_cnt <= pon_cnt + 1'b1;
            hub_oe_n <= !(scan_en && pwm_cnt < brightness);   // lit for brightness slots
        end
    end

    // trigger follows scan in trigger mode, else plain high
    assign hpd_trig = pon_done && (hpd_func ? scan_en : 1'b1);

endmodule

`default_nettype wire

/* src/led_mat_core.sv */
/*
 * Top of the LED matrix core. APB control registers, one clipper and
 * buffer per panel lane, the HUB scan driver and the output enable logic.
 */
`default_nettype none

module led_mat_core import led_core_pkg::*;
#(
    parameter int NUM_LANES        = 3,
    parameter int PON_DELAY_CYCLES = 64
)
(
    input  logic                              clk_pll_dclk,
    input  logic                              dly_rst,
    // apb slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [APB_ADDR_WIDTH-1:0]         paddr,
    input  logic [APB_DATA_WIDTH-1:0]         pwdata,
    output logic [APB_DATA_WIDTH-1:0]         prdata,
    output logic                              pready,
    output logic                              pslverr,
    // pixel stream, no handshake
    input  logic                              pix_valid,
    input  logic [IMG_WIDTH_LOG2-1:0]         pix_h,
    input  logic [IMG_V_LOG2-1:0]             pix_v,
    input  logic [7:0]                        pix_r,
    input  logic [7:0]                        pix_g,
    input  logic [7:0]                        pix_b,
    // hub75 side
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]  hub_r,
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]  hub_g,
    output logic [NUM_LANES*PIXEL_DEPTH-1:0]  hub_b,
    output logic                              hub_clk,
    output logic                              hub_latch,
    output logic [LANE_HEIGHT_LOG2-1:0]       hub_addr,
    output logic                              hub_oe_n,
    output logic                              hpd_trig
);

    logic [1:0]                    gctrl;
    logic [BRIGHTNESS_DEPTH-1:0]   brightness;
    logic [IMG_WIDTH_LOG2-1:0]     image_width;
    logic [LANE_HEIGHT_LOG2-1:0]   lane_height;
    logic [IMG_WIDTH_LOG2-1:0]     roi_x0;
    logic [IMG_V_LOG2-1:0]         roi_y0;

    logic [BUF_ADDR_WIDTH-1:0]           rd_addr;   // common to all lanes
    logic [NUM_LANES-1:0][PIX_WIDTH-1:0] rd_data;

    apb_regfile apb_regfile_inst (
        .clk_pll_dclk (clk_pll_dclk), .dly_rst (dly_rst),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
        .pready (pready), .pslverr (pslverr),
        .gctrl (gctrl), .brightness (brightness),
        .image_width (image_width), .lane_height (lane_height),
        .roi_x0 (roi_x0), .roi_y0 (roi_y0)
    );

    // ------------------------------------------------------------
    // one window + buffer per lane
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : g_lane
        logic                      wr_en;
        logic [BUF_ADDR_WIDTH-1:0] wr_addr;
        logic [PIX_WIDTH-1:0]      wr_data;

        image_clipper #(.LANE_INDEX (k)) image_clipper_inst (
            .clk_pll_dclk (clk_pll_dclk), .dly_rst (dly_rst),
            .pix_valid (pix_valid), .pix_h (pix_h), .pix_v (pix_v),
            .pix_r (pix_r), .pix_g (pix_g), .pix_b (pix_b),
            .image_width (image_width), .lane_height (lane_height),
            .roi_x0 (roi_x0), .roi_y0 (roi_y0),
            .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data)
        );

        lane_buffer lane_buffer_inst (
            .clk_pll_dclk (clk_pll_dclk),
            .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
            .rd_addr (rd_addr), .rd_data (rd_data[k])
        );
    end

    scan_driver #(.NUM_LANES (NUM_LANES)) scan_driver_inst (
        .clk_pll_dclk (clk_pll_dclk), .dly_rst (dly_rst),
        .scan_en (gctrl[0]), .image_width (image_width), .lane_height (lane_height),
        .rd_addr (rd_addr), .rd_data (rd_data),
        .hub_r (hub_r), .hub_g (hub_g), .hub_b (hub_b),
        .hub_clk (hub_clk), .hub_latch (hub_latch), .hub_addr (hub_addr)
    );

    panel_enable_ctrl #(.PON_DELAY_CYCLES (PON_DELAY_CYCLES)) panel_enable_ctrl_inst (
        .clk_pll_dclk (clk_pll_dclk), .dly_rst (dly_rst),
        .scan_en (gctrl[0]), .hpd_func (gctrl[1]), .brightness (brightness),
        .hub_oe_n (hub_oe_n), .hpd_trig (hpd_trig)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
/*
 * Free-running testbench clock, period of 10 time units.
 */
`default_nettype none

module tb_clock_gen
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // half period
    end

endmodule

`default_nettype wire

/* tb/tb_led_mat_core.sv */
/*
 * Testbench of the LED matrix core. Drives APB and a random pixel frame,
 * then checks registers, HUB scan order, PWM duty and the HPD hold-off.
 */
`default_nettype none

module tb_led_mat_core import led_core_pkg::*;
();

    localparam int NUM_LANES        = 3;
    localparam int PON_DELAY_CYCLES = 64;
    localparam int LW               = NUM_LANES * PIXEL_DEPTH;

    logic                        clk_pll_dclk;
    logic                        dly_rst;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [APB_ADDR_WIDTH-1:0]   paddr;
    logic [APB_DATA_WIDTH-1:0]   pwdata;
    logic [APB_DATA_WIDTH-1:0]   prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        pix_valid;
    logic [IMG_WIDTH_LOG2-1:0]   pix_h;
    logic [IMG_V_LOG2-1:0]       pix_v;
    logic [7:0]                  pix_r;
    logic [7:0]                  pix_g;
    logic [7:0]                  pix_b;
    logic [LW-1:0]               hub_r;
    logic [LW-1:0]               hub_g;
    logic [LW-1:0]               hub_b;
    logic                        hub_clk;
    logic                        hub_latch;
    logic [LANE_HEIGHT_LOG2-1:0] hub_addr;
    logic                        hub_oe_n;
    logic                        hpd_trig;

    logic [15:0]          lfsr = 16'd59683;
    int unsigned          regs_m [7];                                  // register model
    logic [PIX_WIDTH-1:0] model_buf [NUM_LANES][2**BUF_ADDR_WIDTH];   // lane buffer model

    tb_clock_gen tb_clock_gen_inst (.clk (clk_pll_dclk));

    led_mat_core #(.NUM_LANES (NUM_LANES), .PON_DELAY_CYCLES (PON_DELAY_CYCLES))
    led_mat_core_inst (
        .clk_pll_dclk (clk_pll_dclk), .dly_rst (dly_rst),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .pix_valid (pix_valid), .pix_h (pix_h), .pix_v (pix_v),
        .pix_r (pix_r), .pix_g (pix_g), .pix_b (pix_b),
        .hub_r (hub_r), .hub_g (hub_g), .hub_b (hub_b), .hub_clk (hub_clk),
        .hub_latch (hub_latch), .hub_addr (hub_addr),
        .hub_oe_n (hub_oe_n), .hpd_trig (hpd_trig)
    );

    // ------------------------------------------------------------
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int unsigned reg_mask(input int addr);
        case (addr)
            GCTRL:                   return 3;
            BRIGHTNESS, LANE_HEIGHT: return 31;
            default:                 return 127;   // width and roi fields
        endcase
    endfunction

    task automatic next_drive();   // inputs move 1 after the edge
        @(posedge clk_pll_dclk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // apb setup phase then access phase with no wait states
    task automatic apb_access(input int addr, input bit wr, input int data, input bit exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = APB_ADDR_WIDTH'(addr);
        pwdata  = APB_DATA_WIDTH'(data);
        next_drive();
        penable = 1'b1;
        @(negedge clk_pll_dclk);
        check_eq("pready", pready, 1);
        check_eq($sformatf("pslverr at addr %0d", addr), pslverr, exp_err);
        if (!wr)
            check_eq($sformatf("prdata at addr %0d", addr), prdata, regs_m[addr]);
        next_drive();
        psel    = 1'b0;
        penable = 1'b0;
        if (wr && !exp_err)
            regs_m[addr] = data & reg_mask(addr);
    endtask

    task automatic read_all_regs();
        for (int a = 0; a <= VERSION; a++)
            apb_access(a, 1'b0, 0, 1'b0);
    endtask

    // ------------------------------------------------------------
    // pixel stream and the lane window model
    task automatic clip_pixel(input int h, input int v, input logic [PIX_WIDTH-1:0] word);
        int dx;
        int dy;
        dx = h - int'(regs_m[ROI_X0]);
        for (int k = 0; k < NUM_LANES; k++)
        begin
            dy = v - int'(regs_m[ROI_Y0] + k * regs_m[LANE_HEIGHT]);
            if (dx >= 0 && dx < int'(regs_m[IMAGE_WIDTH]) && dy >= 0 && dy < int'(regs_m[LANE_HEIGHT]))
                model_buf[k][dy * regs_m[IMAGE_WIDTH] + dx] = word;
        end
    endtask

    task automatic send_frame(input int v_last, input int h_last);
        for (int v = 0; v <= v_last; v++)
            for (int h = 0; h <= h_last; h++)
            begin
                if (rand_bits(2) == 0)   // idle gap with junk on the bus
                begin
                    pix_valid = 1'b0;
                    pix_h     = IMG_WIDTH_LOG2'(rand_bits(IMG_WIDTH_LOG2));
                    pix_v     = IMG_V_LOG2'(rand_bits(IMG_V_LOG2));
                    next_drive();
                end
                pix_valid = 1'b1;
                pix_h     = IMG_WIDTH_LOG2'(h);
                pix_v     = IMG_V_LOG2'(v);
                pix_r     = 8'(rand_bits(8));
                pix_g     = 8'(rand_bits(8));
                pix_b     = 8'(rand_bits(8));
                clip_pixel(h, v, {pix_r[7:2], pix_g[7:2], pix_b[7:2]});
                next_drive();
            end
        pix_valid = 1'b0;
    endtask

    // one full lane scan with strobes then a latch per row
    task automatic check_scan();
        logic [LW-1:0] exp_r;
        logic [LW-1:0] exp_g;
        logic [LW-1:0] exp_b;
        int row;
        int col;
        int idle;
        int a;
        row  = 0;
        col  = 0;
        idle = 0;
        while (row < int'(regs_m[LANE_HEIGHT]))
        begin
            @(negedge clk_pll_dclk);
            idle++;
            if (idle > 16)
                abort_run("timeout: no hub_clk or hub_latch from the scan driver");
            if (hub_clk)
            begin
                if (col >= int'(regs_m[IMAGE_WIDTH]))
                    abort_run("hub_clk strobe after the last pixel of a row");
                a = row * regs_m[IMAGE_WIDTH] + col;
                for (int k = 0; k < NUM_LANES; k++)
                begin
                    exp_r[k*PIXEL_DEPTH +: PIXEL_DEPTH] = model_buf[k][a][17:12];
                    exp_g[k*PIXEL_DEPTH +: PIXEL_DEPTH] = model_buf[k][a][11:6];
                    exp_b[k*PIXEL_DEPTH +: PIXEL_DEPTH] = model_buf[k][a][5:0];
                end
                check_eq("hub_r", hub_r, exp_r);
                check_eq("hub_g", hub_g, exp_g);
                check_eq("hub_b", hub_b, exp_b);
                col++;
                idle = 0;
            end
            else if (hub_latch)
            begin
                check_eq("pixels before hub_latch", col, regs_m[IMAGE_WIDTH]);
                check_eq("hub_addr", hub_addr, row);
                row++;
                col  = 0;
                idle = 0;
            end
        end
        next_drive();
    endtask

    task automatic count_oe(input int exp_low);
        int low;
        low = 0;
        next_drive();   // new brightness reaches the register
        next_drive();
        for (int i = 0; i < 32; i++)
        begin
            @(negedge clk_pll_dclk);
            low += int'(!hub_oe_n);
        end
        check_eq("hub_oe_n low cycles", low, exp_low);
        next_drive();
    endtask

    // ------------------------------------------------------------
    initial
    begin
        int n;
        int idx;
        dly_rst   = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pix_valid = 1'b0;
        pix_h     = '0;
        pix_v     = '0;
        pix_r     = '0;
        pix_g     = '0;
        pix_b     = '0;
        regs_m    = '{0, 16, 64, 16, 0, 0, VERSION_VALUE};   // reset values
        repeat (3) @(posedge clk_pll_dclk);
        #1 dly_rst = 1'b0;

        // outputs after reset then the power-on hold-off
        @(negedge clk_pll_dclk);
        check_eq("hub_clk", hub_clk, 0);
        check_eq("hub_latch", hub_latch, 0);
        check_eq("hub_oe_n", hub_oe_n, 1);
        check_eq("hpd_trig", hpd_trig, 0);
        check_eq("pslverr", pslverr, 0);
        n = 0;
        while (!hpd_trig)
        begin
            @(negedge clk_pll_dclk);
            n++;
            if (n > 4 * PON_DELAY_CYCLES)
                abort_run("timeout: hpd_trig never rose after reset");
        end
        check_eq("hpd_trig delay cycles", n, PON_DELAY_CYCLES);
        next_drive();
        read_all_regs();

        // random register traffic then rejected writes
        for (int i = 0; i < 12; i++)
        begin
            idx = 1 + rand_bits(3) % 5;   // brightness up to roi_y0
            apb_access(idx, 1'b1, rand_bits(16), 1'b0);
            apb_access(idx, 1'b0, 0, 1'b0);
        end
        apb_access(VERSION, 1'b1, rand_bits(16), 1'b1);
        apb_access(7 + rand_bits(3), 1'b1, rand_bits(16), 1'b1);
        read_all_regs();

        // small random geometry and a frame with margins before one scan
        apb_access(IMAGE_WIDTH, 1'b1, 4 + rand_bits(3), 1'b0);
        apb_access(LANE_HEIGHT, 1'b1, 2 + rand_bits(2), 1'b0);
        apb_access(ROI_X0, 1'b1, rand_bits(2), 1'b0);
        apb_access(ROI_Y0, 1'b1, rand_bits(2), 1'b0);
        send_frame(regs_m[ROI_Y0] + NUM_LANES * regs_m[LANE_HEIGHT],
                   regs_m[ROI_X0] + regs_m[IMAGE_WIDTH]);
        next_drive();
        apb_access(GCTRL, 1'b1, 1, 1'b0);
        check_scan();

        // pwm duty while scanning
        for (int i = 0; i < 4; i++)
        begin
            idx = rand_bits(BRIGHTNESS_DEPTH);
            apb_access(BRIGHTNESS, 1'b1, idx, 1'b0);
            count_oe(idx);
        end

        // hpd trigger mode follows scan enable
        apb_access(GCTRL, 1'b1, 3, 1'b0);
        @(negedge clk_pll_dclk);
        check_eq("hpd_trig", hpd_trig, 1);
        next_drive();
        apb_access(GCTRL, 1'b1, 2, 1'b0);
        @(negedge clk_pll_dclk);
        check_eq("hpd_trig", hpd_trig, 0);
        next_drive();
        apb_access(BRIGHTNESS, 1'b1, 31, 1'b0);   // full duty if it were lit
        count_oe(0);   // scan off keeps the panel dark
        apb_access(GCTRL, 1'b1, 0, 1'b0);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/led_core_pkg.sv
frame_buffer/image_clipper.sv
frame_buffer/lane_buffer.sv
src/apb_regfile.sv
src/scan_driver.sv
src/panel_enable_ctrl.sv
src/led_mat_core.sv
tb/tb_clock_gen.sv
tb/tb_led_mat_core.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_led_mat_core -o sim_tb || exit 1
out="$(./obj_dir/sim_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed' && exit 0 || exit 1
